// ==== src/axi_bridge_pkg.sv ====
// bridge package: bus widths, cache line geometry, request kinds and AXI burst codes
package axi_bridge_pkg;

  // ----------------------------------------
  // bus and line geometry
  // ----------------------------------------
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 64;
  localparam int unsigned strb_width = data_width / 8;
  localparam int unsigned id_width   = 4;

  // four 64-bit beats make one 32-byte line
  localparam int unsigned line_words       = 4;
  localparam int unsigned line_offset_bits = 5;
  localparam int unsigned word_offset_bits = 3;
  localparam int unsigned beat_idx_width   = 2;

  // ----------------------------------------
  // AXI encodings
  // ----------------------------------------
  localparam logic [1:0] burst_incr = 2'b01;
  // 8 bytes per beat
  localparam logic [2:0] size_word  = 3'd3;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] word_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [id_width-1:0]   id_t;

  // word i of a line sits at bits [64*i +: 64]
  typedef word_t [line_words-1:0] line_t;
  typedef strb_t [line_words-1:0] line_strb_t;

  typedef logic [beat_idx_width-1:0] beat_idx_t;

  // one word or a whole line
  typedef enum logic {
    single_req = 1'b0,
    line_req   = 1'b1
  } req_kind_e;

endpackage

// ==== src/axi_write_ctrl.sv ====
// write controller: issues AW, streams the W beats of a word or a line and collects B
module axi_write_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // client request
  input  logic                        req_i,
  input  axi_bridge_pkg::req_kind_e   kind_i,
  input  axi_bridge_pkg::addr_t       addr_i,
  input  axi_bridge_pkg::line_t       wdata_i,
  input  axi_bridge_pkg::line_strb_t  be_i,
  input  axi_bridge_pkg::id_t         id_i,
  output logic                        gnt_o,
  output logic                        busy_o,
  output logic                        valid_o,
  output axi_bridge_pkg::id_t         id_o,
  // AW channel
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output axi_bridge_pkg::addr_t       awaddr_o,
  output logic [7:0]                  awlen_o,
  output logic [2:0]                  awsize_o,
  output logic [1:0]                  awburst_o,
  output axi_bridge_pkg::id_t         awid_o,
  // W channel
  output logic                        wvalid_o,
  input  logic                        wready_i,
  output axi_bridge_pkg::word_t       wdata_o,
  output axi_bridge_pkg::strb_t       wstrb_o,
  output logic                        wlast_o,
  // B channel
  input  logic                        bvalid_i,
  output logic                        bready_o,
  input  axi_bridge_pkg::id_t         bid_i
);
  import axi_bridge_pkg::*;

  // wait_aw: AW and W both pending, wait_w: AW done,
  // wait_aw_after_w: all W beats done
  typedef enum logic [2:0] {
    idle,
    wait_aw,
    wait_w,
    wait_aw_after_w,
    wait_b
  } state_e;

  state_e    state_q, state_d;
  beat_idx_t cnt_q, cnt_d;
  logic      last_beat;

  // request fields are held by the client until gnt_o
  assign last_beat = (kind_i == single_req) || (cnt_q == beat_idx_t'(line_words - 1));

  assign awaddr_o  = addr_i;
  assign awlen_o   = (kind_i == line_req) ? 8'(line_words - 1) : 8'd0;
  assign awsize_o  = size_word;
  assign awburst_o = burst_incr;
  assign awid_o    = id_i;

  // beat counter picks the word, single writes stay on word 0
  assign wdata_o = wdata_i[cnt_q];
  assign wstrb_o = be_i[cnt_q];
  assign wlast_o = last_beat;

  assign busy_o = (state_q != idle);
  assign id_o   = bid_i;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    awvalid_o = 1'b0;
    wvalid_o  = 1'b0;
    bready_o  = 1'b0;
    gnt_o     = 1'b0;
    valid_o   = 1'b0;

    case (state_q)
      idle, wait_aw: begin
        if (req_i || state_q == wait_aw) begin
          awvalid_o = 1'b1;
          wvalid_o  = 1'b1;
          state_d   = wait_aw;
          case ({awready_i, wready_i})
            2'b11: begin
              cnt_d = cnt_q + 1'b1;
              if (last_beat) begin
                gnt_o   = 1'b1;
                state_d = wait_b;
              end else begin
                state_d = wait_w;
              end
            end
            2'b10: state_d = wait_w;
            2'b01: begin
              cnt_d = cnt_q + 1'b1;
              if (last_beat) begin
                state_d = wait_aw_after_w;
              end
            end
            default: ;
          endcase
        end
      end

      wait_w: begin
        wvalid_o = 1'b1;
        if (wready_i) begin
          cnt_d = cnt_q + 1'b1;
          if (last_beat) begin
            gnt_o   = 1'b1;
            state_d = wait_b;
          end
        end
      end

      wait_aw_after_w: begin
        awvalid_o = 1'b1;
        if (awready_i) begin
          gnt_o   = 1'b1;
          state_d = wait_b;
        end
      end

      wait_b: begin
        // counter restarts at word 0 for the next request
        cnt_d    = '0;
        bready_o = 1'b1;
        if (bvalid_i) begin
          valid_o = 1'b1;
          state_d = idle;
        end
      end

      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_wvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_o && !wready_i |=> wvalid_o);

  // no beat may follow the one carrying wlast
  a_wlast_final: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_o && wready_i && wlast_o |=> !wvalid_o);

endmodule

// ==== src/axi_read_ctrl.sv ====
// read controller: issues AR, assembles R beats into a line and flags the critical word
module axi_read_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // client request
  input  logic                       req_i,
  input  axi_bridge_pkg::req_kind_e  kind_i,
  input  axi_bridge_pkg::addr_t      addr_i,
  input  axi_bridge_pkg::id_t        id_i,
  output logic                       gnt_o,
  output logic                       busy_o,
  // client response
  output logic                       valid_o,
  output axi_bridge_pkg::line_t      rdata_o,
  output axi_bridge_pkg::id_t        id_o,
  output axi_bridge_pkg::word_t      critical_word_o,
  output logic                       critical_word_valid_o,
  // AR channel
  output logic                       arvalid_o,
  input  logic                       arready_i,
  output axi_bridge_pkg::addr_t      araddr_o,
  output logic [7:0]                 arlen_o,
  output logic [2:0]                 arsize_o,
  output logic [1:0]                 arburst_o,
  output axi_bridge_pkg::id_t        arid_o,
  // R channel
  input  logic                       rvalid_i,
  output logic                       rready_o,
  input  axi_bridge_pkg::word_t      rdata_i,
  input  axi_bridge_pkg::id_t        rid_i,
  input  logic                       rlast_i
);
  import axi_bridge_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_r,
    complete
  } state_e;

  state_e    state_q, state_d;
  beat_idx_t cnt_q, cnt_d;
  req_kind_e kind_q, kind_d;
  beat_idx_t offset_q, offset_d;
  id_t       id_q;
  line_t     line_q;
  logic      ar_fire;
  logic      r_fire;

  // ----------------------------------------
  // AR channel
  // ----------------------------------------
  assign arvalid_o = (state_q == idle) && req_i;
  assign ar_fire   = arvalid_o && arready_i;
  assign gnt_o     = ar_fire;

  // a line burst always starts at the line base
  always_comb begin
    araddr_o = addr_i;
    arlen_o  = 8'd0;
    if (kind_i == line_req) begin
      araddr_o = {addr_i[addr_width-1:line_offset_bits], {line_offset_bits{1'b0}}};
      arlen_o  = 8'(line_words - 1);
    end
  end

  assign arsize_o  = size_word;
  assign arburst_o = burst_incr;
  assign arid_o    = id_i;

  // ----------------------------------------
  // R channel and client side
  // ----------------------------------------
  // rready stays up while waiting so every beat is taken at once
  assign rready_o = (state_q == wait_r);
  assign r_fire   = rvalid_i && rready_o;

  assign critical_word_o       = rdata_i;
  assign critical_word_valid_o = r_fire && (kind_q == line_req) && (cnt_q == offset_q);

  assign busy_o  = (state_q != idle);
  assign valid_o = (state_q == complete);
  assign rdata_o = line_q;
  assign id_o    = id_q;

  always_comb begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    kind_d   = kind_q;
    offset_d = offset_q;

    case (state_q)
      idle: begin
        if (ar_fire) begin
          state_d  = wait_r;
          cnt_d    = '0;
          kind_d   = kind_i;
          offset_d = addr_i[word_offset_bits +: beat_idx_width];
        end
      end

      wait_r: begin
        if (r_fire) begin
          cnt_d = cnt_q + 1'b1;
          if (rlast_i) begin
            state_d = complete;
          end
        end
      end

      complete: state_d = idle;

      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= idle;
      cnt_q    <= '0;
      kind_q   <= single_req;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      kind_q   <= kind_d;
      offset_q <= offset_d;
    end
  end

  // line buffer filled by beat index, single read lands in word 0
  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      if (kind_q == line_req) begin
        line_q[cnt_q] <= rdata_i;
      end else begin
        line_q[0] <= rdata_i;
      end
      if (rlast_i) begin
        id_q <= rid_i;
      end
    end
  end

  // slave must not present read data with no burst outstanding
  a_no_r_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == idle) |-> !rvalid_i);

endmodule

// ==== src/axi_bridge.sv ====
// cache to AXI4 bridge top: steers requests to the read or write controller
module axi_bridge (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // client request
  input  logic                        req_i,
  input  logic                        we_i,
  input  axi_bridge_pkg::req_kind_e   kind_i,
  input  axi_bridge_pkg::addr_t       addr_i,
  input  axi_bridge_pkg::line_t       wdata_i,
  input  axi_bridge_pkg::line_strb_t  be_i,
  input  axi_bridge_pkg::id_t         id_i,
  output logic                        gnt_o,
  output logic                        busy_o,
  // client response
  output logic                        valid_o,
  output axi_bridge_pkg::line_t       rdata_o,
  output axi_bridge_pkg::id_t         id_o,
  output axi_bridge_pkg::word_t       critical_word_o,
  output logic                        critical_word_valid_o,
  // AW channel
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output axi_bridge_pkg::addr_t       awaddr_o,
  output logic [7:0]                  awlen_o,
  output logic [2:0]                  awsize_o,
  output logic [1:0]                  awburst_o,
  output axi_bridge_pkg::id_t         awid_o,
  // W channel
  output logic                        wvalid_o,
  input  logic                        wready_i,
  output axi_bridge_pkg::word_t       wdata_o,
  output axi_bridge_pkg::strb_t       wstrb_o,
  output logic                        wlast_o,
  // B channel
  input  logic                        bvalid_i,
  output logic                        bready_o,
  input  axi_bridge_pkg::id_t         bid_i,
  // AR channel
  output logic                        arvalid_o,
  input  logic                        arready_i,
  output axi_bridge_pkg::addr_t       araddr_o,
  output logic [7:0]                  arlen_o,
  output logic [2:0]                  arsize_o,
  output logic [1:0]                  arburst_o,
  output axi_bridge_pkg::id_t         arid_o,
  // R channel
  input  logic                        rvalid_i,
  output logic                        rready_o,
  input  axi_bridge_pkg::word_t       rdata_i,
  input  axi_bridge_pkg::id_t         rid_i,
  input  logic                        rlast_i
);
  import axi_bridge_pkg::*;

  logic wr_req, wr_gnt, wr_busy, wr_valid;
  logic rd_req, rd_gnt, rd_busy, rd_valid;
  id_t  wr_id, rd_id;

  // ----------------------------------------
  // steering
  // ----------------------------------------
  // a controller only sees a request while the other one is idle
  assign wr_req = req_i && we_i && !rd_busy;
  assign rd_req = req_i && !we_i && !wr_busy;

  // only one side is active, so a plain merge is enough
  assign gnt_o   = wr_gnt || rd_gnt;
  assign busy_o  = wr_busy || rd_busy;
  assign valid_o = wr_valid || rd_valid;
  assign id_o    = wr_valid ? wr_id : rd_id;

  axi_write_ctrl i_write_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (wr_req),
    .kind_i    (kind_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .be_i      (be_i),
    .id_i      (id_i),
    .gnt_o     (wr_gnt),
    .busy_o    (wr_busy),
    .valid_o   (wr_valid),
    .id_o      (wr_id),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .awaddr_o  (awaddr_o),
    .awlen_o   (awlen_o),
    .awsize_o  (awsize_o),
    .awburst_o (awburst_o),
    .awid_o    (awid_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wlast_o   (wlast_o),
    .bvalid_i  (bvalid_i),
    .bready_o  (bready_o),
    .bid_i     (bid_i)
  );

  axi_read_ctrl i_read_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (rd_req),
    .kind_i                (kind_i),
    .addr_i                (addr_i),
    .id_i                  (id_i),
    .gnt_o                 (rd_gnt),
    .busy_o                (rd_busy),
    .valid_o               (rd_valid),
    .rdata_o               (rdata_o),
    .id_o                  (rd_id),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .arvalid_o             (arvalid_o),
    .arready_i             (arready_i),
    .araddr_o              (araddr_o),
    .arlen_o               (arlen_o),
    .arsize_o              (arsize_o),
    .arburst_o             (arburst_o),
    .arid_o                (arid_o),
    .rvalid_i              (rvalid_i),
    .rready_o              (rready_o),
    .rdata_i               (rdata_i),
    .rid_i                 (rid_i),
    .rlast_i               (rlast_i)
  );

  // at most one transaction in flight across both controllers
  a_one_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_busy && rd_busy));

endmodule

// ==== test/axi_mem_slave.sv ====
// AXI memory model: 64-word array with strobed writes and random channel delays
module axi_mem_slave (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  axi_bridge_pkg::addr_t  awaddr_i,
  input  axi_bridge_pkg::id_t    awid_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  axi_bridge_pkg::word_t  wdata_i,
  input  axi_bridge_pkg::strb_t  wstrb_i,
  input  logic                   wlast_i,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output axi_bridge_pkg::id_t    bid_o,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  axi_bridge_pkg::addr_t  araddr_i,
  input  logic [7:0]             arlen_i,
  input  axi_bridge_pkg::id_t    arid_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output axi_bridge_pkg::word_t  rdata_o,
  output axi_bridge_pkg::id_t    rid_o,
  output logic                   rlast_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import axi_bridge_pkg::*;

  // filled by the testbench before reset is released
  word_t      mem [0:63];
  logic       aw_got, w_done, ar_busy;
  logic [5:0] aw_idx, r_idx;
  id_t        aw_id, r_id;
  word_t      wq_data [0:3];
  strb_t      wq_strb [0:3];
  logic [2:0] wn;
  logic [7:0] r_len, r_cnt;

  function automatic logic chance();
    return ($urandom_range(3, 0) != 0);
  endfunction

  // ----------------------------------------
  // write side: W beats may arrive before AW
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin : write_side
    int i;
    int b;
    if (!rst_ni) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      aw_got    <= 1'b0;
      w_done    <= 1'b0;
      wn        <= '0;
    end else begin
      awready_o <= !aw_got && !(awvalid_i && awready_o) && chance();
      wready_o  <= !w_done && !(wvalid_i && wready_o && wlast_i) && chance();
      if (awvalid_i && awready_o && !aw_got) begin
        aw_got <= 1'b1;
        aw_idx <= awaddr_i[8:3];
        aw_id  <= awid_i;
      end
      if (wvalid_i && wready_o && !w_done) begin
        wq_data[wn[1:0]] <= wdata_i;
        wq_strb[wn[1:0]] <= wstrb_i;
        wn <= wn + 3'd1;
        w_done <= wlast_i;
      end
      if (aw_got && w_done && !bvalid_o && chance()) begin
        for (i = 0; i < 4; i++) begin
          if (i < int'(wn)) begin
            for (b = 0; b < 8; b++) begin
              if (wq_strb[i][b]) begin
                mem[aw_idx + 6'(i)][8*b +: 8] <= wq_data[i][8*b +: 8];
              end
            end
          end
        end
        bvalid_o <= 1'b1;
        bid_o    <= aw_id;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        aw_got   <= 1'b0;
        w_done   <= 1'b0;
        wn       <= '0;
      end
    end
  end

  // ----------------------------------------
  // read side: one burst at a time
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rlast_o   <= 1'b0;
      ar_busy   <= 1'b0;
    end else begin
      arready_o <= !ar_busy && !(arvalid_i && arready_o) && chance();
      if (arvalid_i && arready_o && !ar_busy) begin
        ar_busy <= 1'b1;
        r_idx   <= araddr_i[8:3];
        r_len   <= arlen_i;
        r_id    <= arid_i;
        r_cnt   <= '0;
      end else if (ar_busy) begin
        if (rvalid_o && rready_i) begin
          rvalid_o <= 1'b0;
          r_cnt    <= r_cnt + 8'd1;
          if (rlast_o) begin
            ar_busy <= 1'b0;
          end
        end else if (!rvalid_o && chance()) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[r_idx + r_cnt[5:0]];
          rid_o    <= r_id;
          rlast_o  <= (r_cnt == r_len);
        end
      end
    end
  end

endmodule

// ==== test/tb_axi_bridge.sv ====
// testbench for the cache to AXI4 bridge with directed and mixed random transfers
module tb_axi_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_bridge_pkg::*;

  localparam int max_cycles = 4000;

  logic clk_i, rst_ni;
  logic req_i, we_i, gnt_o, busy_o, valid_o, critical_word_valid_o;
  req_kind_e kind_i;
  addr_t addr_i, awaddr, araddr;
  line_t wdata_i, rdata_o;
  line_strb_t be_i;
  id_t id_i, id_o, awid, bid, arid, rid;
  word_t critical_word_o, wdata, rdata;
  strb_t wstrb;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [7:0] awlen, arlen;
  logic [2:0] awsize, arsize;
  logic [1:0] awburst, arburst;

  word_t ref_mem [0:63];
  int value_errors = 0;
  int protocol_errors = 0;
  int cycles = 0;

  axi_bridge dut (
    .clk_i, .rst_ni, .req_i, .we_i, .kind_i, .addr_i, .wdata_i, .be_i, .id_i,
    .gnt_o, .busy_o, .valid_o, .rdata_o, .id_o, .critical_word_o, .critical_word_valid_o,
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awlen_o(awlen),
    .awsize_o(awsize), .awburst_o(awburst), .awid_o(awid),
    .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
    .bvalid_i(bvalid), .bready_o(bready), .bid_i(bid),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arlen_o(arlen),
    .arsize_o(arsize), .arburst_o(arburst), .arid_o(arid),
    .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata), .rid_i(rid), .rlast_i(rlast)
  );

  axi_mem_slave u_mem (
    .clk_i, .rst_ni,
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast),
    .bvalid_o(bvalid), .bready_i(bready), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
    .arid_i(arid), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rid_o(rid),
    .rlast_o(rlast)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout: bridge did not finish within %0d cycles", max_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_line(input string name, input line_t exp, input line_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_len(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_size(input string name, input logic [2:0] exp, input logic [2:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_burst(input string name, input logic [1:0] exp,
                             input logic [1:0] act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic protocol_error(input string name, input string what);
    $display("%s: %s", name, what);
    protocol_errors++;
  endtask

  // ----------------------------------------
  // drives one transfer and checks it end to end
  // ----------------------------------------
  task automatic run_txn(input string name, input logic we, input req_kind_e kind,
                         input addr_t addr, input line_t wd, input line_strb_t be,
                         input id_t id);
    logic [5:0] idx;
    int gnts;
    int crits;
    bit done;
    bit drop;
    bit form_seen;
    word_t crit_word;
    line_t got_line;
    line_t exp_line;
    id_t got_id;
    idx = (kind == line_req) ? {addr[8:5], 2'b00} : addr[8:3];
    gnts = 0;
    crits = 0;
    done = 0;
    form_seen = 0;
    req_i = 1'b1;
    we_i = we;
    kind_i = kind;
    addr_i = addr;
    wdata_i = wd;
    be_i = be;
    id_i = id;
    while (!done) begin
      @(negedge clk_i);
      drop = 0;
      if (!form_seen && (we ? awvalid : arvalid)) begin
        form_seen = 1;
        if (kind == line_req) begin
          check_addr({name, " addr"}, {addr[31:5], 5'b0}, we ? awaddr : araddr);
          check_len({name, " len"}, 8'd3, we ? awlen : arlen);
        end else begin
          check_addr({name, " addr"}, addr, we ? awaddr : araddr);
          check_len({name, " len"}, 8'd0, we ? awlen : arlen);
        end
        // 8-byte beats in an incrementing burst
        check_size({name, " size"}, 3'd3, we ? awsize : arsize);
        check_burst({name, " burst"}, 2'b01, we ? awburst : arburst);
      end
      if (gnt_o) begin
        gnts++;
        drop = 1;
      end
      if (critical_word_valid_o) begin
        crits++;
        crit_word = critical_word_o;
      end
      if (valid_o) begin
        done = 1;
        got_line = rdata_o;
        got_id = id_o;
        if (!busy_o) protocol_error(name, "busy_o was low while valid_o pulsed");
      end
      @(posedge clk_i);
      #2;
      if (drop) req_i = 1'b0;
    end
    @(negedge clk_i);
    if (valid_o) protocol_error(name, "valid_o stayed high for more than one cycle");
    if (busy_o) protocol_error(name, "busy_o stayed high after the transfer completed");
    @(posedge clk_i);
    #2;
    if (gnts != 1) protocol_error(name, "expected exactly one grant for the request");
    check_id({name, " id"}, id, got_id);
    if (we) begin
      for (int i = 0; i < ((kind == line_req) ? 4 : 1); i++) begin
        for (int b = 0; b < 8; b++) begin
          if (be[i][b]) ref_mem[idx + 6'(i)][8*b +: 8] = wd[i][8*b +: 8];
        end
      end
    end else if (kind == line_req) begin
      for (int i = 0; i < 4; i++) exp_line[i] = ref_mem[idx + 6'(i)];
      check_line({name, " line"}, exp_line, got_line);
      if (crits != 1) protocol_error(name, "critical word flag did not pulse exactly once");
      else check_word({name, " critical"}, exp_line[addr[4:3]], crit_word);
    end else begin
      check_word({name, " word"}, ref_mem[idx], got_line[0]);
      if (crits != 0) protocol_error(name, "critical word flagged on a single read");
    end
  endtask

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < 4; i++) l[i] = {$urandom, $urandom};
    return l;
  endfunction

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_single_rw();
    run_txn("single_write", 1'b1, single_req, 32'h48, rand_line(), 32'h0000_003c, 4'h3);
    run_txn("single_read", 1'b0, single_req, 32'h48, '0, '0, 4'h5);
  endtask

  task automatic test_line_rw();
    run_txn("line_write", 1'b1, line_req, 32'h100, rand_line(), '1, 4'h9);
    run_txn("line_read", 1'b0, line_req, 32'h100, '0, '0, 4'ha);
    run_txn("line_read_unaligned", 1'b0, line_req, 32'h11c, '0, '0, 4'hb);
  endtask

  task automatic test_critical_word();
    for (int k = 0; k < 4; k++) begin
      run_txn("critical_word", 1'b0, line_req, 32'h40 + addr_t'(8 * k) + 32'h2, '0, '0,
              id_t'(k));
    end
  endtask

  task automatic test_random_mix();
    logic we;
    req_kind_e kind;
    addr_t addr;
    for (int n = 0; n < 30; n++) begin
      we = 1'($urandom);
      kind = req_kind_e'(1'($urandom));
      addr = {23'b0, 9'($urandom)};
      if (kind == line_req && we) addr[4:0] = '0;
      run_txn("random_mix", we, kind, addr, rand_line(), $urandom, 4'($urandom));
    end
  endtask

  initial begin
    void'($urandom(8841));
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    kind_i = single_req;
    addr_i = '0;
    wdata_i = '0;
    be_i = '0;
    id_i = '0;
    // every word holds its own byte address and its inverse
    for (int i = 0; i < 64; i++) begin
      ref_mem[i] = {32'(i * 8), ~32'(i * 8)};
      u_mem.mem[i] = {32'(i * 8), ~32'(i * 8)};
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;
    test_single_rw();
    test_line_rw();
    test_critical_word();
    test_random_mix();
    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/axi_bridge_pkg.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_bridge.sv
test/axi_mem_slave.sv
test/tb_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the bridge simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing --assert \
  --top-module tb_axi_bridge \
  --Mdir build -o sim_axi_bridge \
  -f project.f

# the simulator status is not trusted, the log decides
./build/sim_axi_bridge | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  exit 1
fi
